/* sources.f */
logic/uartPkg.sv
logic/baudTickGen.sv
logic/uartBitTimer.sv
logic/uartTransmitter.sv
logic/uartReceiver.sv
logic/echoController.sv
logic/uartEcho.sv
test/uartEchoTb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the uart echo testbench with Verilator and runs it
# exit status is nonzero when the build fails or the testbench stops on $fatal

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
  --top-module uartEchoTb \
  -f sources.f \
  -o uartEchoSim \
  && ./obj_dir/uartEchoSim \
  || { echo "simulation run failed"; exit 1; }

/* test/uartEchoTb.sv */
// testbench for the uart echo port, drives 8N1 frames on rxd and decodes the echo on txd
`timescale 1ns/100ps

module uartEchoTb;
  import uartPkg::*;

  localparam int BitCycles   = ClkPerTick * TicksPerBit;  // 256 clk per bit
  localparam int EchoTimeout = 40 * BitCycles;            // per echoed frame
  localparam int QuietBits   = 15;                        // bad stop watch window

  logic clk_29_pll;
  logic reset;
  logic rxd;
  logic txd;

  uartByte expectQ[$];  // bytes sent with a good stop, oldest first

  uartEcho i_dut (
    .clk_29_pll (clk_29_pll),
    .reset      (reset),
    .rxd        (rxd),
    .txd        (txd)
  );

  always #2 clk_29_pll = ~clk_29_pll;  // 4 ns period

  // ------------------------------------------------------------------
  // failure reporting and checks
  // ------------------------------------------------------------------
  task automatic abortRun(string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic checkBit(string name, logic expected, logic actual);
    assert (actual === expected) else begin
      abortRun($sformatf("** Error @ %0d ns: %s expected %b, got %b",
                         $time, name, expected, actual));
    end
  endtask

  task automatic checkByte(string name, uartByte expected, uartByte actual);
    assert (actual === expected) else begin
      abortRun($sformatf("** Error @ %0d ns: %s expected 8'h%02h, got 8'h%02h",
                         $time, name, expected, actual));
    end
  endtask

  // ------------------------------------------------------------------
  // rxd driver
  // ------------------------------------------------------------------
  // one frame, start + 8 data lsb first + stop, all on falling edges
  task automatic sendFrame(uartByte data, bit goodStop);
    logic [9:0] frame;
    if (goodStop) begin
      expectQ.push_back(data);  // only good frames come back
    end
    frame = {goodStop ? 1'b1 : 1'b0, data, 1'b0};
    for (int s = 0; s < 10; s++) begin
      @(negedge clk_29_pll);
      rxd = frame[0];
      frame = frame >> 1;
      repeat (BitCycles - 1) @(negedge clk_29_pll);
    end
  endtask

  // line high for a number of bit times, also lifts a low stop bit
  task automatic idleBits(int bits);
    if (bits > 0) begin
      @(negedge clk_29_pll);
      rxd = 1'b1;
      repeat (bits * BitCycles - 1) @(negedge clk_29_pll);
    end
  endtask

  // ------------------------------------------------------------------
  // txd decoder
  // ------------------------------------------------------------------
  task automatic holdHigh(int cycles);
    for (int c = 0; c < cycles; c++) begin
      @(negedge clk_29_pll);
      checkBit("txd", 1'b1, txd);  // idle line, no start edge
    end
  endtask

  task automatic waitStartEdge(int limit);
    int waited;
    waited = 0;
    @(negedge clk_29_pll);
    while (txd !== 1'b0) begin
      if (waited >= limit) begin
        abortRun($sformatf("timeout at %0d ns: no start bit on txd after %0d cycles",
                           $time, limit));
      end
      waited++;
      @(negedge clk_29_pll);
    end
  endtask

  // samples at mid-bit, counted from the cycle the start edge was seen
  task automatic receiveFrame(output uartByte data);
    data = '0;
    waitStartEdge(EchoTimeout);
    repeat (BitCycles / 2) @(negedge clk_29_pll);
    checkBit("txd start bit", 1'b0, txd);
    for (int b = 0; b < 8; b++) begin
      repeat (BitCycles) @(negedge clk_29_pll);
      data = {txd, data[7:1]};  // lsb first
    end
    repeat (BitCycles) @(negedge clk_29_pll);
    checkBit("txd stop bit", 1'b1, txd);
  endtask

  task automatic checkEchoes(int count);
    uartByte got;
    uartByte want;
    for (int n = 0; n < count; n++) begin
      receiveFrame(got);
      want = expectQ.pop_front();
      checkByte("txd data", want, got);
    end
  endtask

  // ------------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------------
  initial begin
    uartByte rnd;
    int      gap;

    clk_29_pll = 1'b0;
    reset      = 1'b0;
    rxd        = 1'b1;  // idle line
    void'($urandom(32'ha177));

    // 1. line idle through reset and 20 bit times after
    repeat (5) begin
      @(negedge clk_29_pll);
      checkBit("txd", 1'b1, txd);
    end
    reset = 1'b1;
    holdHigh(20 * BitCycles);

    // 2. single byte
    fork
      sendFrame(8'hA5, 1'b1);
      checkEchoes(1);
    join

    // 3. three back to back
    fork
      begin
        sendFrame(8'h00, 1'b1);
        sendFrame(8'hFF, 1'b1);
        sendFrame(8'h3C, 1'b1);
      end
      checkEchoes(3);
    join

    // 4. framing error dropped, next byte still echoed
    fork
      begin
        sendFrame(8'h5A, 1'b0);
        idleBits(QuietBits);
      end
      holdHigh((10 + QuietBits) * BitCycles);
    join
    fork
      sendFrame(8'hC3, 1'b1);
      checkEchoes(1);
    join

    // 5. random bytes, random idle gaps 0..3 bits
    fork
      begin
        for (int n = 0; n < 20; n++) begin
          gap = int'($urandom_range(3, 0));
          idleBits(gap);
          rnd = uartByte'($urandom);
          sendFrame(rnd, 1'b1);
        end
      end
      checkEchoes(20);
    join

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

/* logic/uartEcho.sv */
// top level of the serial echo port, every good byte on rxd is sent back on txd
`timescale 1ns/100ps

module uartEcho (
  input  logic clk_29_pll,  // 29.49 MHz
  input  logic reset,       // sync, active low
  input  logic rxd,         // serial in, 115200 8N1
  output logic txd          // serial out, echo
);
  import uartPkg::*;

  logic    tick;     // 16x baud enable
  uartByte rxData;
  logic    rxValid;
  uartByte txData;
  logic    txStart;
  logic    txBusy;

  // ------------------------------------------------------------------
  // baud tick
  // ------------------------------------------------------------------
  baudTickGen i_tickGen (
    .clk_29_pll (clk_29_pll),
    .reset      (reset),
    .tick       (tick)
  );

  // ------------------------------------------------------------------
  // receive -> hold -> transmit
  // ------------------------------------------------------------------
  uartReceiver i_rx (
    .clk_29_pll (clk_29_pll),
    .reset      (reset),
    .tick       (tick),
    .rxd        (rxd),
    .rxData     (rxData),
    .rxValid    (rxValid)
  );

  echoController i_ctrl (
    .clk_29_pll (clk_29_pll),
    .reset      (reset),
    .rxValid    (rxValid),
    .rxData     (rxData),
    .txBusy     (txBusy),
    .txData     (txData),
    .txStart    (txStart)
  );

  uartTransmitter i_tx (
    .clk_29_pll (clk_29_pll),
    .reset      (reset),
    .tick       (tick),
    .txData     (txData),
    .txStart    (txStart),
    .txd        (txd),
    .txBusy     (txBusy)
  );

endmodule

/* logic/echoController.sv */
// echo FSM, holds one received byte until the transmitter is free and then launches it
`timescale 1ns/100ps

module echoController (
  input  logic             clk_29_pll,
  input  logic             reset,
  input  logic             rxValid,  // one cycle, rxData valid
  input  uartPkg::uartByte rxData,
  input  logic             txBusy,
  output uartPkg::uartByte txData,   // held byte
  output logic             txStart   // one cycle launch pulse
);
  import uartPkg::*;

  echoState state;

  // ------------------------------------------------------------------
  // byte holding register
  // ------------------------------------------------------------------
  // a byte arriving before launch simply overwrites (overrun)
  always_ff @(posedge clk_29_pll) begin
    if (rxValid) begin
      txData <= rxData;
    end
  end

  // ------------------------------------------------------------------
  // state machine
  // ------------------------------------------------------------------
  always_ff @(posedge clk_29_pll) begin
    if (!reset) begin
      state <= Idle;
    end else begin
      case (state)
        Idle: begin
          if (rxValid) begin
            // go straight out if tx is free
            if (txBusy) begin
              state <= Held;
            end else begin
              state <= Launch;
            end
          end
        end
        Held: begin
          if (!txBusy) begin
            state <= Launch;  // one cycle after busy falls
          end
        end
        Launch: begin
          // tx goes busy next cycle, so a new byte must wait
          if (rxValid) begin
            state <= Held;
          end else begin
            state <= Idle;
          end
        end
        default: begin
          state <= Idle;
        end
      endcase
    end
  end

  // pulse only exists in Launch, tx is idle there by construction
  assign txStart = (state == Launch);

endmodule

/* logic/uartReceiver.sv */
// 8N1 receiver, finds the start edge on rxd, samples the data bits and checks the stop bit
`timescale 1ns/100ps

module uartReceiver (
  input  logic             clk_29_pll,
  input  logic             reset,
  input  logic             tick,
  input  logic             rxd,      // async serial line
  output uartPkg::uartByte rxData,   // valid while rxValid
  output logic             rxValid   // one cycle per good frame
);
  import uartPkg::*;

  logic [3:0] rxSamples;  // tick-rate samples, [3] oldest
  logic       lineBit;    // latest sample
  logic       startEdge;
  logic       running;
  logic       strobe;
  bitSlot     slot;
  logic       dataSlot;
  logic       stopSlot;
  uartByte    rxHold;     // assembles data bits

  // ------------------------------------------------------------------
  // line sampling and start detect
  // ------------------------------------------------------------------
  // preset to idle-high so reset release can't look like an edge
  always_ff @(posedge clk_29_pll) begin
    if (!reset) begin
      rxSamples <= 4'hF;
    end else if (tick) begin
      rxSamples <= {rxSamples[2:0], rxd};
    end
  end

  assign lineBit = rxSamples[0];

  // two high then two low, ignored mid-frame
  assign startEdge = ~running & rxSamples[3] & rxSamples[2] & ~rxSamples[1] & ~rxSamples[0];

  uartBitTimer #(
    .StrobePhase (tickPhase'(RxStrobePhase))
  ) i_rxTimer (
    .clk_29_pll (clk_29_pll),
    .reset      (reset),
    .tick       (tick),
    .start      (startEdge),
    .slot       (slot),
    .strobe     (strobe),
    .frameDone  (),
    .running    (running)
  );

  assign dataSlot = (slot != '0) && (slot < bitSlot'(StopSlot));
  assign stopSlot = (slot == bitSlot'(StopSlot));

  // ------------------------------------------------------------------
  // data capture
  // ------------------------------------------------------------------
  // lsb arrives first, so shift in from the top
  always_ff @(posedge clk_29_pll) begin
    if (strobe && dataSlot) begin
      rxHold <= {lineBit, rxHold[7:1]};
    end
  end

  // publish on stop strobe, framing error drops the byte
  always_ff @(posedge clk_29_pll) begin
    if (strobe && stopSlot && lineBit) begin
      rxData <= rxHold;
    end
  end

  always_ff @(posedge clk_29_pll) begin
    if (!reset) begin
      rxValid <= 1'b0;
    end else begin
      rxValid <= strobe & stopSlot & lineBit;  // stop bit must read high
    end
  end

endmodule

/* logic/uartTransmitter.sv */
// 8N1 transmitter, latches a byte on txStart and shifts start, data and stop bits onto txd
`timescale 1ns/100ps

module uartTransmitter (
  input  logic             clk_29_pll,
  input  logic             reset,
  input  logic             tick,
  input  uartPkg::uartByte txData,
  input  logic             txStart,  // one cycle, only while !txBusy
  output logic             txd,      // serial line, idles high
  output logic             txBusy
);
  import uartPkg::*;

  bitSlot  slot;
  logic    strobe;
  logic    frameDone;
  logic    dataSlot;  // slots 1..8 carry data
  uartByte txShift;   // byte being sent, lsb out first

  uartBitTimer #(
    .StrobePhase (tickPhase'(TxStrobePhase))
  ) i_txTimer (
    .clk_29_pll (clk_29_pll),
    .reset      (reset),
    .tick       (tick),
    .start      (txStart),
    .slot       (slot),
    .strobe     (strobe),
    .frameDone  (frameDone),
    .running    ()
  );

  assign dataSlot = (slot != '0) && (slot < bitSlot'(StopSlot));

  // payload shifter
  always_ff @(posedge clk_29_pll) begin
    if (txStart) begin
      txShift <= txData;  // latch
    end else if (strobe && dataSlot) begin
      txShift <= txShift >> 1;  // next data bit into bit 0
    end
  end

  // ------------------------------------------------------------------
  // line driver and busy flag
  // ------------------------------------------------------------------
  always_ff @(posedge clk_29_pll) begin
    if (!reset) begin
      txd    <= 1'b1;
      txBusy <= 1'b0;
    end else begin
      if (txStart) begin
        txBusy <= 1'b1;
      end else if (frameDone) begin
        txBusy <= 1'b0;  // drops the cycle after stop slot ends
      end
      if (strobe) begin
        if (slot == '0) begin
          txd <= 1'b0;          // start bit
        end else if (dataSlot) begin
          txd <= txShift[0];
        end else begin
          txd <= 1'b1;          // stop bit, then idle
        end
      end
    end
  end

endmodule

/* logic/uartBitTimer.sv */
// frame timer that counts baud ticks into bit slots and phases, one per tx and rx side
`timescale 1ns/100ps

module uartBitTimer #(
  parameter uartPkg::tickPhase StrobePhase = '0   // phase that fires strobe
) (
  input  logic            clk_29_pll,
  input  logic            reset,
  input  logic            tick,       // 16x baud enable
  input  logic            start,      // begin a frame at slot 0
  output uartPkg::bitSlot slot,       // current slot
  output logic            strobe,     // one tick per slot at StrobePhase
  output logic            frameDone,  // last tick of the stop slot
  output logic            running
);
  import uartPkg::*;

  tickPhase phase;     // tick count inside the slot
  logic     lastTick;  // final tick of current slot

  assign lastTick  = (phase == tickPhase'(TicksPerBit - 1));
  assign strobe    = running & tick & (phase == StrobePhase);
  assign frameDone = running & tick & lastTick & (slot == bitSlot'(FrameSlots - 1));

  // ------------------------------------------------------------------
  // slot / phase counters, frozen while idle
  // ------------------------------------------------------------------
  always_ff @(posedge clk_29_pll) begin
    if (!reset) begin
      running <= 1'b0;
      slot    <= '0;
      phase   <= '0;
    end else if (start) begin
      running <= 1'b1;  // restart from the top
      slot    <= '0;
      phase   <= '0;
    end else if (running && tick) begin
      if (frameDone) begin
        // end of stop slot, park at zero
        running <= 1'b0;
        slot    <= '0;
        phase   <= '0;
      end else if (lastTick) begin
        slot  <= slot + 1'b1;  // next bit slot
        phase <= '0;
      end else begin
        phase <= phase + 1'b1;
      end
    end
  end

endmodule

/* logic/baudTickGen.sv */
// divides clk_29_pll into the one-cycle 16x baud tick enable used by both bit timers
`timescale 1ns/100ps

module baudTickGen (
  input  logic clk_29_pll,
  input  logic reset,
  output logic tick         // one cycle high every ClkPerTick clocks
);
  import uartPkg::*;

  logic [$clog2(ClkPerTick)-1:0] divCount;  // free running divider

  // registered tick, high in the cycle after the divider wraps
  always_ff @(posedge clk_29_pll) begin
    if (!reset) begin
      divCount <= '0;
      tick     <= 1'b0;
    end else begin
      divCount <= divCount + 1'b1;  // wraps naturally at ClkPerTick
      // fire once per wrap
      if (divCount == ($clog2(ClkPerTick))'(ClkPerTick - 1)) begin
        tick <= 1'b1;
      end else begin
        tick <= 1'b0;
      end
    end
  end

endmodule

/* logic/uartPkg.sv */
// uart frame constants and types shared by the echo rtl and its testbench, import with uartPkg::*
package uartPkg;

  // ------------------------------------------------------------------
  // baud timing
  // ------------------------------------------------------------------
  localparam int ClkPerTick  = 16;  // 29.49 MHz / 16 = 1.8432 MHz tick
  localparam int TicksPerBit = 16;  // 16x oversampling, 256 clk per bit

  // tick phase inside a slot where each side acts
  localparam int TxStrobePhase = 0;  // tx drives line at slot start
  localparam int RxStrobePhase = 6;  // plus 2 ticks of edge detect ~ mid-bit

  // ------------------------------------------------------------------
  // frame layout, 8N1
  // ------------------------------------------------------------------
  // slot 0 start, slots 1..8 data lsb first, slot 9 stop
  localparam int StopSlot   = 9;
  localparam int FrameSlots = 10;

  typedef logic [7:0] uartByte;   // one data byte
  typedef logic [3:0] bitSlot;    // slot index 0..9
  typedef logic [3:0] tickPhase;  // tick within a slot 0..15

  // echo controller states
  typedef enum logic [1:0] {
    Idle   = 2'd0,  // nothing held
    Held   = 2'd1,  // byte waiting for tx to free up
    Launch = 2'd2   // txStart pulse cycle
  } echoState;

endpackage
